//--- icache.f
+incdir+.
icache_pkg.sv
icache_array.sv
icache_miss_ctrl.sv
icache.sv
tb_imem_model.sv
tb_icache.sv

//--- icache.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache (
    input  logic                                           clock,
    input  logic                                           reset,

    // fetch side
    input  logic [`ICACHE_WAYS-1:0][31:0]                  proc2icache_addr,
    input  logic [`ICACHE_WAYS-1:0]                        proc2icache_en,
    output logic [`ICACHE_WAYS-1:0][`ICACHE_LINE_BITS-1:0] icache_data_out,
    output logic [`ICACHE_WAYS-1:0]                        icache_valid_out,

    // memory side
    output icache_pkg::bus_command_e                       proc2imem_command,
    output logic [31:0]                                    proc2imem_addr,
    input  logic [`IMEM_TAG_BITS-1:0]                      imem2proc_response,
    input  logic [`ICACHE_LINE_BITS-1:0]                   imem2proc_data,
    input  logic [`IMEM_TAG_BITS-1:0]                      imem2proc_tag
);

    logic [`ICACHE_WAYS-1:0][`ICACHE_LINE_BITS-1:0] line_data;
    logic [`ICACHE_WAYS-1:0]                        line_hit;

    logic                          fill_en;
    logic [`ICACHE_INDEX_BITS-1:0] fill_index;
    logic [`ICACHE_TAG_BITS-1:0]   fill_tag;

    icache_array i_array (
        .clock       (clock),
        .reset       (reset),
        .lookup_addr (proc2icache_addr),
        .lookup_en   (proc2icache_en),
        .fill_en     (fill_en),
        .fill_index  (fill_index),
        .fill_tag    (fill_tag),
        .fill_data   (imem2proc_data),   // returned block goes straight in
        .line_data   (line_data),
        .line_hit    (line_hit)
    );

    icache_miss_ctrl i_miss_ctrl (
        .clock              (clock),
        .reset              (reset),
        .fetch_addr         (proc2icache_addr),
        .fetch_en           (proc2icache_en),
        .line_hit           (line_hit),
        .imem2proc_response (imem2proc_response),
        .imem2proc_tag      (imem2proc_tag),
        .proc2imem_command  (proc2imem_command),
        .proc2imem_addr     (proc2imem_addr),
        .fill_en            (fill_en),
        .fill_index         (fill_index),
        .fill_tag           (fill_tag)
    );

    // a hit is what the fetch stage sees as valid
    assign icache_data_out  = line_data;
    assign icache_valid_out = line_hit;

endmodule

//--- icache_array.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_array (
    input  logic                                           clock,
    input  logic                                           reset,

    // lookup side, one port per fetch way
    input  logic [`ICACHE_WAYS-1:0][31:0]                  lookup_addr,
    input  logic [`ICACHE_WAYS-1:0]                        lookup_en,

    // fill side, driven by the miss controller
    input  logic                                           fill_en,
    input  logic [`ICACHE_INDEX_BITS-1:0]                  fill_index,
    input  logic [`ICACHE_TAG_BITS-1:0]                    fill_tag,
    input  logic [`ICACHE_LINE_BITS-1:0]                   fill_data,

    output logic [`ICACHE_WAYS-1:0][`ICACHE_LINE_BITS-1:0] line_data,
    output logic [`ICACHE_WAYS-1:0]                        line_hit
);

    logic [`ICACHE_LINE_BITS-1:0] data_mem [`ICACHE_LINES];
    logic [`ICACHE_TAG_BITS-1:0]  tag_mem  [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0]     valid_bits;

    // address fields split out per port
    logic [`ICACHE_WAYS-1:0][`ICACHE_INDEX_BITS-1:0] lookup_index;
    logic [`ICACHE_WAYS-1:0][`ICACHE_TAG_BITS-1:0]   lookup_tag;

    genvar w;
    generate
        for (w = 0; w < `ICACHE_WAYS; w++) begin : g_lookup
            assign lookup_index[w] = lookup_addr[w][`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
            assign lookup_tag[w]   = lookup_addr[w][`ICACHE_TAG_LSB +: `ICACHE_TAG_BITS];

            // data goes out regardless, hit qualifies it
            assign line_data[w] = data_mem[lookup_index[w]];

            assign line_hit[w] = lookup_en[w]
                              && valid_bits[lookup_index[w]]
                              && (tag_mem[lookup_index[w]] == lookup_tag[w]);
        end
    endgenerate

    // valid bits, cleared on reset and set by a fill
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (fill_en) begin
            valid_bits[fill_index] <= 1'b1;
        end
    end

    // a fill overwrites whatever block held this index before
    always_ff @(posedge clock) begin
        if (fill_en) begin
            data_mem[fill_index] <= fill_data;
            tag_mem[fill_index]  <= fill_tag;
        end
    end

endmodule

//--- icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// fetch ports looked up in parallel
`define ICACHE_WAYS 4

// 32 direct-mapped lines of one 64-bit block each
`define ICACHE_INDEX_BITS 5
`define ICACHE_LINES (1 << `ICACHE_INDEX_BITS)
`define ICACHE_LINE_BITS 64

// byte offset inside a block, index sits right above it
`define ICACHE_OFFSET_BITS 3

// tag covers address bits 15:8, i.e. a 64 KB space
`define ICACHE_TAG_BITS 8
`define ICACHE_TAG_LSB (`ICACHE_OFFSET_BITS + `ICACHE_INDEX_BITS)

// memory transaction tag, 0 = rejected / no data
`define IMEM_TAG_BITS 4

`endif

//--- icache_miss_ctrl.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_miss_ctrl (
    input  logic                                  clock,
    input  logic                                  reset,

    // fetch side as the array sees it
    input  logic [`ICACHE_WAYS-1:0][31:0]         fetch_addr,
    input  logic [`ICACHE_WAYS-1:0]               fetch_en,
    input  logic [`ICACHE_WAYS-1:0]               line_hit,

    // memory bus
    input  logic [`IMEM_TAG_BITS-1:0]             imem2proc_response,
    input  logic [`IMEM_TAG_BITS-1:0]             imem2proc_tag,
    output icache_pkg::bus_command_e              proc2imem_command,
    output logic [31:0]                           proc2imem_addr,

    // fill write into the array
    output logic                                  fill_en,
    output logic [`ICACHE_INDEX_BITS-1:0]         fill_index,
    output logic [`ICACHE_TAG_BITS-1:0]           fill_tag
);

    localparam int SEL_BITS = $clog2(`ICACHE_WAYS);

    icache_pkg::miss_state_e state;
    icache_pkg::miss_state_e state_next;

    logic [`IMEM_TAG_BITS-1:0]     mem_tag;     // tag of the outstanding load
    logic [`ICACHE_INDEX_BITS-1:0] pend_index;
    logic [`ICACHE_TAG_BITS-1:0]   pend_tag;

    logic [`ICACHE_WAYS-1:0] way_miss;
    logic                    any_miss;
    logic [SEL_BITS-1:0]     sel_way;
    logic [31:0]             sel_addr;
    logic                    req_accepted;
    logic                    tag_match;

    assign way_miss = fetch_en & ~line_hit;
    assign any_miss = |way_miss;

    // scan downward so the lowest missing way is kept last
    always_comb begin
        sel_way = '0;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (way_miss[w]) begin
                sel_way = SEL_BITS'(w);
            end
        end
    end

    assign sel_addr = fetch_addr[sel_way];

    // combinational request, held off in reset and while a load is pending
    always_comb begin
        proc2imem_command = icache_pkg::BUS_NONE;
        proc2imem_addr    = '0;
        if (!reset && (state == icache_pkg::MISS_IDLE) && any_miss) begin
            proc2imem_command = icache_pkg::BUS_LOAD;
            proc2imem_addr    = {sel_addr[31:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};
        end
    end

    // a zero response is a reject and the load repeats next cycle
    assign req_accepted = (proc2imem_command == icache_pkg::BUS_LOAD)
                       && (imem2proc_response != '0);

    assign tag_match = (state == icache_pkg::MISS_WAIT)
                    && (mem_tag != '0)
                    && (imem2proc_tag == mem_tag);

    assign fill_en    = tag_match;
    assign fill_index = pend_index;
    assign fill_tag   = pend_tag;

    always_comb begin
        state_next = state;
        case (state)
            icache_pkg::MISS_IDLE: begin
                if (req_accepted) begin
                    state_next = icache_pkg::MISS_WAIT;
                end
            end
            icache_pkg::MISS_WAIT: begin
                if (tag_match) begin   // back to idle on the fill edge
                    state_next = icache_pkg::MISS_IDLE;
                end
            end
            default: begin
                state_next = icache_pkg::MISS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= icache_pkg::MISS_IDLE;
            mem_tag <= '0;
        end else begin
            state <= state_next;
            if (req_accepted) begin
                mem_tag <= imem2proc_response;
            end else if (tag_match) begin
                mem_tag <= '0;   // nothing pending any more
            end
        end
    end

    // block location captured with the accepted tag
    always_ff @(posedge clock) begin
        if (req_accepted) begin
            pend_index <= sel_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
            pend_tag   <= sel_addr[`ICACHE_TAG_LSB +: `ICACHE_TAG_BITS];
        end
    end

endmodule

//--- icache_pkg.sv
package icache_pkg;

    // memory bus command, same encoding the memory model decodes
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2   // never issued by the icache
    } bus_command_e;

    // miss controller state
    typedef enum logic {
        MISS_IDLE = 1'b0,  // free to send a load
        MISS_WAIT = 1'b1   // load accepted, data still pending
    } miss_state_e;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# build the icache testbench with Verilator, run it, and judge by the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert --top-module tb_icache -f icache.f -o tb_icache_sim \
    && ./obj_dir/tb_icache_sim > "$log" 2>&1 \
    || echo "build or simulation returned an error"

cat "$log" 2>/dev/null

grep -q "^ALL CHECKS PASSED$" "$log" 2>/dev/null && echo "result: pass" && exit 0 \
    || echo "result: fail"
exit 1

//--- tb_icache.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module tb_icache;

    localparam int WAYS     = `ICACHE_WAYS;
    localparam int TIMEOUT  = 300;    // cycles per wait loop
    localparam int WATCHDOG = 5000;

    logic                                           clock;
    logic                                           reset;
    logic [WAYS-1:0][31:0]                          proc2icache_addr;
    logic [WAYS-1:0]                                proc2icache_en;
    logic [WAYS-1:0][`ICACHE_LINE_BITS-1:0]         icache_data_out;
    logic [WAYS-1:0]                                icache_valid_out;
    icache_pkg::bus_command_e                       proc2imem_command;
    logic [31:0]                                    proc2imem_addr;
    logic [`IMEM_TAG_BITS-1:0]                      imem2proc_response;
    logic [`ICACHE_LINE_BITS-1:0]                   imem2proc_data;
    logic [`IMEM_TAG_BITS-1:0]                      imem2proc_tag;

    // reference cache contents rebuilt from bus traffic
    logic [`ICACHE_LINES-1:0]                       ref_valid;
    logic [`ICACHE_TAG_BITS-1:0]                    ref_tag [`ICACHE_LINES];
    logic                                           ref_busy;
    logic [`IMEM_TAG_BITS-1:0]                      ref_mem_tag;
    logic [31:0]                                    ref_block;
    logic [WAYS-1:0]                                ref_hit;
    logic [WAYS-1:0]                                ref_miss;
    logic [31:0]                                    exp_req_addr;
    logic [WAYS-1:0][`ICACHE_LINE_BITS-1:0]         exp_data;

    int    error_count  = 0;
    int    test_count   = 0;
    int    fail_count   = 0;
    int    reject_count = 0;
    int    fill_count   = 0;
    int    errors_before;
    int    fills_before;
    bit    test_ok;
    string test_name;

    icache i_icache (
        .clock              (clock),
        .reset              (reset),
        .proc2icache_addr   (proc2icache_addr),
        .proc2icache_en     (proc2icache_en),
        .icache_data_out    (icache_data_out),
        .icache_valid_out   (icache_valid_out),
        .proc2imem_command  (proc2imem_command),
        .proc2imem_addr     (proc2imem_addr),
        .imem2proc_response (imem2proc_response),
        .imem2proc_data     (imem2proc_data),
        .imem2proc_tag      (imem2proc_tag)
    );

    tb_imem_model i_imem (
        .clock              (clock),
        .reset              (reset),
        .proc2imem_command  (proc2imem_command),
        .proc2imem_addr     (proc2imem_addr),
        .imem2proc_response (imem2proc_response),
        .imem2proc_data     (imem2proc_data),
        .imem2proc_tag      (imem2proc_tag)
    );

    always #10 clock = ~clock;

    function automatic logic [31:0] block_addr(input logic [31:0] addr);
        return {addr[31:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};
    endfunction

    function automatic logic [63:0] rule_value(input logic [31:0] block);
        return {block, ~block};   // address in the high half and its inverse in the low half
    endfunction

    always_comb begin
        logic [`ICACHE_INDEX_BITS-1:0] idx;
        idx          = '0;
        ref_hit      = '0;
        exp_req_addr = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            idx = proc2icache_addr[w][`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
            ref_hit[w] = proc2icache_en[w] && ref_valid[idx]
                      && (ref_tag[idx] == proc2icache_addr[w][`ICACHE_TAG_LSB +: `ICACHE_TAG_BITS]);
            exp_data[w] = rule_value(block_addr(proc2icache_addr[w]));
            if (proc2icache_en[w] && !ref_hit[w]) begin
                exp_req_addr = block_addr(proc2icache_addr[w]);   // lowest way ends up last
            end
        end
        ref_miss = proc2icache_en & ~ref_hit;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ref_valid   <= '0;
            ref_busy    <= 1'b0;
            ref_mem_tag <= '0;
            ref_block   <= '0;
        end else if (ref_busy) begin
            if (imem2proc_tag == ref_mem_tag) begin
                ref_valid[ref_block[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS]] <= 1'b1;
                ref_tag[ref_block[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS]] <=
                    ref_block[`ICACHE_TAG_LSB +: `ICACHE_TAG_BITS];
                ref_busy <= 1'b0;
            end
        end else if ((proc2imem_command == icache_pkg::BUS_LOAD)
                     && (imem2proc_response != '0)) begin
            ref_busy    <= 1'b1;
            ref_mem_tag <= imem2proc_response;
            ref_block   <= exp_req_addr;
        end
    end

    always @(posedge clock) begin
        if (!reset && (proc2imem_command == icache_pkg::BUS_LOAD) && (imem2proc_response == '0)) begin
            reject_count <= reject_count + 1;
        end
        if (!reset && ref_busy && (imem2proc_tag == ref_mem_tag)) begin
            fill_count <= fill_count + 1;
        end
    end

    reset_bus_idle: assert property (@(posedge clock)
        (reset || $fell(reset)) |-> (proc2imem_command == icache_pkg::BUS_NONE))
        else begin
            error_count++;
            $display("ERROR proc2imem_command got %h expected %h around reset",
                     $sampled(proc2imem_command), icache_pkg::BUS_NONE);
        end

    reset_all_invalid: assert property (@(posedge clock)
        (reset || $fell(reset)) |-> (icache_valid_out == '0))
        else begin
            error_count++;
            $display("ERROR icache_valid_out got %h expected 0 around reset",
                     $sampled(icache_valid_out));
        end

    // a free controller must ask for the lowest missing way at once
    miss_requests_load: assert property (@(posedge clock) disable iff (reset)
        (!ref_busy && (|ref_miss)) |->
            (proc2imem_command == icache_pkg::BUS_LOAD) && (proc2imem_addr == exp_req_addr))
        else begin
            error_count++;
            $display("ERROR proc2imem_command/proc2imem_addr got %h/%h expected %h/%h",
                     $sampled(proc2imem_command), $sampled(proc2imem_addr),
                     icache_pkg::BUS_LOAD, $sampled(exp_req_addr));
        end

    no_miss_no_request: assert property (@(posedge clock) disable iff (reset)
        (ref_busy || !(|ref_miss)) |-> (proc2imem_command == icache_pkg::BUS_NONE))
        else begin
            error_count++;
            $display("ERROR proc2imem_command got %h expected %h (busy %h, miss %h)",
                     $sampled(proc2imem_command), icache_pkg::BUS_NONE,
                     $sampled(ref_busy), $sampled(ref_miss));
        end

    retry_after_reject: assert property (@(posedge clock) disable iff (reset)
        ($past((proc2imem_command == icache_pkg::BUS_LOAD) && (imem2proc_response == '0))
            && (|ref_miss)) |-> (proc2imem_command == icache_pkg::BUS_LOAD))
        else begin
            error_count++;
            $display("ERROR proc2imem_command got %h expected %h after a reject",
                     $sampled(proc2imem_command), icache_pkg::BUS_LOAD);
        end

    valid_matches_contents: assert property (@(posedge clock) disable iff (reset)
        icache_valid_out == ref_hit)
        else begin
            error_count++;
            $display("ERROR icache_valid_out got %h expected %h",
                     $sampled(icache_valid_out), $sampled(ref_hit));
        end

    genvar g;
    generate
        for (g = 0; g < WAYS; g++) begin : g_data_check
            hit_data_ok: assert property (@(posedge clock) disable iff (reset)
                ref_hit[g] |-> (icache_data_out[g] == exp_data[g]))
                else begin
                    error_count++;
                    $display("ERROR icache_data_out[%0d] got %h expected %h", g,
                             $sampled(icache_data_out[g]), $sampled(exp_data[g]));
                end
        end
    endgenerate

    task automatic start_test(input string name);
        test_name     = name;
        errors_before = error_count;
        test_ok       = 1'b1;
    endtask

    task automatic finish_test();
        test_count++;
        if (test_ok && (error_count == errors_before)) begin
            $display("test %0d %s: ok", test_count, test_name);
        end else begin
            fail_count++;
            $display("test %0d %s: failed", test_count, test_name);
        end
    endtask

    task automatic present(input logic [WAYS-1:0] en, input logic [31:0] a0, a1, a2, a3);
        @(negedge clock);
        proc2icache_addr[0] = a0;
        proc2icache_addr[1] = a1;
        proc2icache_addr[2] = a2;
        proc2icache_addr[3] = a3;
        proc2icache_en      = en;
    endtask

    task automatic wait_for_valid(input logic [WAYS-1:0] mask, input string what);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && (cycles < TIMEOUT)) begin
            @(negedge clock);
            seen = ((icache_valid_out & mask) == mask);
            cycles++;
        end
        if (!seen) begin
            $display("timeout after %0d cycles waiting for %s", TIMEOUT, what);
            test_ok = 1'b0;
        end
    endtask

    initial begin
        clock            = 1'b0;
        reset            = 1'b1;
        proc2icache_addr = '0;
        proc2icache_en   = '0;

        start_test("reset");
        @(posedge clock);   // first edge clears the valid bits
        present(4'b1111, 32'h0000_123c, 32'h0000_2040, 32'h0000_305c, 32'h0000_4174);
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset          = 1'b0;
        proc2icache_en = '0;   // first cycle out of reset with no fetch
        @(negedge clock);
        finish_test();

        start_test("single miss");
        present(4'b0001, 32'h0000_123c, 32'h0, 32'h0, 32'h0);
        wait_for_valid(4'b0001, "way 0 to fill");
        finish_test();

        start_test("second port hits same block");
        present(4'b0101, 32'h0000_123c, 32'h0, 32'h0000_1238, 32'h0);
        wait_for_valid(4'b0101, "ways 0 and 2 to hit");
        finish_test();

        start_test("four ways four indexes");
        fills_before = fill_count;
        present(4'b1111, 32'h0000_2040, 32'h0000_305c, 32'h0000_4174, 32'h0000_50f8);
        wait_for_valid(4'b1111, "all four ways to fill");
        if ((fill_count - fills_before) != 4) begin
            $display("ERROR fill count got %h expected %h", fill_count - fills_before, 4);
            test_ok = 1'b0;
        end
        finish_test();

        start_test("eviction and refetch");
        present(4'b0001, 32'h0000_1100, 32'h0, 32'h0, 32'h0);
        wait_for_valid(4'b0001, "way 0 to fill the older block");
        present(4'b0011, 32'h0000_1100, 32'h0000_2200, 32'h0, 32'h0);
        wait_for_valid(4'b0010, "way 1 to fill the same index");
        if (icache_valid_out[0]) begin
            $display("ERROR icache_valid_out[0] got %h expected %h", icache_valid_out[0], 1'b0);
            test_ok = 1'b0;
        end
        present(4'b0001, 32'h0000_1100, 32'h0000_2200, 32'h0, 32'h0);
        wait_for_valid(4'b0001, "way 0 to refetch the older block");
        finish_test();

        present('0, 32'h0, 32'h0, 32'h0, 32'h0);
        repeat (2) @(negedge clock);
        if (reject_count == 0) begin
            $display("no load was ever rejected, so the retry path was not exercised");
            error_count++;
        end
        $display("tests %0d, failed tests %0d, errors %0d, rejects %0d, fills %0d",
                 test_count, fail_count, error_count, reject_count, fill_count);
        if ((error_count == 0) && (fail_count == 0)) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // hard stop in case a wait loop is ever bypassed
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < WATCHDOG) begin
            @(posedge clock);
            cycles++;
        end
        $display("simulation ran past %0d cycles without finishing", WATCHDOG);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- tb_imem_model.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module tb_imem_model (
    input  logic                             clock,
    input  logic                             reset,

    // request side, from the icache
    input  icache_pkg::bus_command_e         proc2imem_command,
    input  logic [31:0]                      proc2imem_addr,

    // answer in the request cycle, data later
    output logic [`IMEM_TAG_BITS-1:0]        imem2proc_response,
    output logic [`ICACHE_LINE_BITS-1:0]     imem2proc_data,
    output logic [`IMEM_TAG_BITS-1:0]        imem2proc_tag
);

    localparam logic [31:0] SEED = 32'ha0e390ae;

    logic [31:0]               rng;
    logic [`IMEM_TAG_BITS-1:0] next_tag;     // cycles through 1..15
    logic                      pend_valid;
    logic [31:0]               pend_addr;
    logic [`IMEM_TAG_BITS-1:0] pend_tag;
    logic [3:0]                pend_count;   // cycles left before data
    logic [31:0]               delay_pick;
    logic                      accept;
    logic                      deliver;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // roughly one load in three gets turned away
    assign accept = (proc2imem_command == icache_pkg::BUS_LOAD)
                 && !pend_valid
                 && ((rng % 32'd3) != 32'd0);

    assign delay_pick = 32'd1 + ((rng >> 8) % 32'd7);   // 2..8 cycles, minus one

    assign imem2proc_response = accept ? next_tag : '0;

    assign deliver        = pend_valid && (pend_count == 4'd0);
    assign imem2proc_tag  = deliver ? pend_tag : '0;
    assign imem2proc_data = deliver ? {pend_addr, ~pend_addr} : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            rng        <= SEED;
            next_tag   <= 4'd1;
            pend_valid <= 1'b0;
            pend_addr  <= '0;
            pend_tag   <= '0;
            pend_count <= '0;
        end else begin
            if (proc2imem_command == icache_pkg::BUS_LOAD) begin
                rng <= xorshift32(rng);   // one draw per request cycle
            end
            if (accept) begin
                pend_valid <= 1'b1;
                pend_addr  <= proc2imem_addr;
                pend_tag   <= next_tag;
                pend_count <= delay_pick[3:0];
                next_tag   <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end else if (pend_valid) begin
                if (pend_count == 4'd0) begin
                    pend_valid <= 1'b0;   // data went out this cycle
                end else begin
                    pend_count <= pend_count - 4'd1;
                end
            end
        end
    end

endmodule
